//--- files.f
hdl/ooo_pkg.sv
hdl/rs_if.sv
hdl/cdb_if.sv
hdl/issue_unit.sv
hdl/rs_entry.sv
hdl/exec_broadcast.sv
hdl/ooo_core_top.sv
sim/tb_clock.sv
sim/tb_ooo_core.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_ooo_core
FILELIST  = files.f
PASS_TEXT = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- sim/tb_ooo_core.sv
`timescale 1ns/1ns

module tb_ooo_core;

    localparam int PROG_LEN = 400;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 20;

    logic clk;
    logic rst;
    logic instr_valid;
    ooo_pkg::instr_t instr;
    ooo_pkg::word_t pc;
    logic take;
    logic illegal;
    logic wb_valid;
    ooo_pkg::tag_t wb_tag;
    ooo_pkg::reg_idx_t wb_rd;
    ooo_pkg::word_t wb_data;
    ooo_pkg::word_t wb_pc;

    // program, in-order model and per-pc expectations
    ooo_pkg::instr_t prog [PROG_LEN];
    ooo_pkg::word_t model_regs [32];
    ooo_pkg::reg_idx_t exp_rd [PROG_LEN];
    ooo_pkg::word_t exp_data [PROG_LEN];
    logic pending [PROG_LEN];

    int outstanding = 0;
    int accepted_count = 0;
    int expected_wb = 0;
    int wb_count = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycles = 0;
    int next_idx = 0;
    logic seen_take = 1'b0;

    tb_clock #(.PERIOD_NS(4)) i_tb_clock (.clk_o(clk));

    ooo_core_top i_ooo_core_top (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .instr_take_o  (take),
        .illegal_o     (illegal),
        .wb_valid_o    (wb_valid),
        .wb_tag_o      (wb_tag),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .wb_pc_o       (wb_pc)
    );

    task automatic check_word(input ooo_pkg::word_t got, input ooo_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input ooo_pkg::reg_idx_t got, input ooo_pkg::reg_idx_t exp,
                             input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t ns: %s got x%0d expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic opcode_supported(input logic [6:0] opc);
        return (opc == ooo_pkg::OPC_LUI) || (opc == ooo_pkg::OPC_AUIPC) ||
               (opc == ooo_pkg::OPC_IMM) || (opc == ooo_pkg::OPC_REG);
    endfunction

    // mostly a small hot set so dependency chains form
    function automatic ooo_pkg::reg_idx_t pick_reg();
        if ($urandom_range(3, 0) == 0) begin
            return ooo_pkg::reg_idx_t'($urandom_range(31, 0));
        end
        return ooo_pkg::reg_idx_t'($urandom_range(5, 0));
    endfunction

    function automatic ooo_pkg::instr_t make_instr();
        int kind;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        kind = int'($urandom_range(99, 0));
        f3 = 3'($urandom_range(7, 0));
        imm = 12'($urandom);
        f7 = 7'b0000000;
        if (kind < 10) begin
            return {20'($urandom), pick_reg(), ooo_pkg::OPC_LUI};
        end else if (kind < 20) begin
            return {20'($urandom), pick_reg(), ooo_pkg::OPC_AUIPC};
        end else if (kind < 52) begin
            // shift immediates carry funct7 in the upper bits
            if (f3 == 3'd1) begin
                imm[11:5] = 7'b0000000;
            end else if (f3 == 3'd5) begin
                imm[11:5] = ($urandom_range(1, 0) != 0) ? 7'b0100000 : 7'b0000000;
            end
            return {imm, pick_reg(), f3, pick_reg(), ooo_pkg::OPC_IMM};
        end else if (kind < 85) begin
            if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) != 0) begin
                f7 = 7'b0100000;
            end
            return {f7, pick_reg(), pick_reg(), f3, pick_reg(), ooo_pkg::OPC_REG};
        end
        // load, store or branch
        case ($urandom_range(2, 0))
            0: return {25'($urandom), 7'b0000011};
            1: return {25'($urandom), 7'b0100011};
            default: return {25'($urandom), 7'b1100011};
        endcase
    endfunction

    // RV32I semantics over the model register file
    function automatic ooo_pkg::word_t expected_value(input ooo_pkg::instr_t ins,
                                                      input ooo_pkg::word_t ipc);
        ooo_pkg::word_t a;
        ooo_pkg::word_t b;
        ooo_pkg::word_t imm_i;
        ooo_pkg::word_t res;
        logic is_reg;
        a = model_regs[ins[19:15]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        is_reg = (ins[6:0] == ooo_pkg::OPC_REG);
        b = is_reg ? model_regs[ins[24:20]] : imm_i;
        if (ins[6:0] == ooo_pkg::OPC_LUI) begin
            return {ins[31:12], 12'h000};
        end
        if (ins[6:0] == ooo_pkg::OPC_AUIPC) begin
            return ipc + {ins[31:12], 12'h000};
        end
        case (ins[14:12])
            3'd0: res = (is_reg && ins[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: res = ins[30] ? ooo_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // sampled mid-cycle away from the driving edge
    always @(negedge clk) begin : monitor
        int idx;
        logic bad_opc;
        if (!rst) begin
            if (wb_valid) begin
                check_flag(int'(wb_tag) >= 1 && int'(wb_tag) <= ooo_pkg::NUM_RS, 1'b1,
                           "wb_tag_o in range");
                idx = int'(wb_pc >> 2);
                if (idx >= PROG_LEN || !pending[idx]) begin
                    other_errors++;
                    $display("writeback at %0t ns names pc %h, which has no result due",
                             $time, wb_pc);
                end else begin
                    check_reg(wb_rd, exp_rd[idx], "wb_rd_o");
                    check_word(wb_data, exp_data[idx], "wb_data_o");
                    pending[idx] = 1'b0;
                    outstanding--;
                    wb_count++;
                end
            end
            bad_opc = !opcode_supported(instr[6:0]);
            check_flag(take, instr_valid && (bad_opc || outstanding < ooo_pkg::NUM_RS),
                       "instr_take_o");
            check_flag(illegal, instr_valid && bad_opc, "illegal_o");
            seen_take = instr_valid && take;
            if (instr_valid && take && !bad_opc && instr[11:7] != 5'd0) begin
                idx = int'(pc >> 2);
                exp_rd[idx] = instr[11:7];
                exp_data[idx] = expected_value(instr, pc);
                model_regs[instr[11:7]] = exp_data[idx];
                pending[idx] = 1'b1;
                outstanding++;
                accepted_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not drain within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        void'($urandom(88));
        for (int n = 0; n < 32; n++) begin
            model_regs[n] = '0;
        end
        for (int n = 0; n < PROG_LEN; n++) begin
            prog[n] = make_instr();
            pending[n] = 1'b0;
            // accepted opcodes with a nonzero rd owe one writeback
            if (opcode_supported(prog[n][6:0]) && prog[n][11:7] != 5'd0) begin
                expected_wb++;
            end
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // idle cycles with all outputs low
        repeat (3) @(posedge clk);
        while (next_idx < PROG_LEN) begin
            @(posedge clk);
            if (!instr_valid || seen_take) begin
                if ($urandom_range(4, 0) != 0) begin
                    instr_valid <= 1'b1;
                    instr <= prog[next_idx];
                    pc <= ooo_pkg::word_t'(next_idx * 4);
                    next_idx++;
                end else begin
                    instr_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        while (!seen_take) begin
            @(posedge clk);
        end
        instr_valid <= 1'b0;
        while (outstanding != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (wb_count != expected_wb) begin
            other_errors++;
            $display("%0d results due from the program, %0d accepted, %0d written back",
                     expected_wb, accepted_count, wb_count);
        end
        $display("errors: %0d value mismatches, %0d other, %0d writebacks checked",
                 value_errors, other_errors, wb_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

//--- hdl/ooo_core_top.sv
`timescale 1ns/1ns

module ooo_core_top (
    input  logic                clk,
    input  logic                rst,

    // instruction queue side
    input  logic                instr_valid_i,
    input  ooo_pkg::instr_t     instr_i,
    input  ooo_pkg::word_t      pc_i,
    output logic                instr_take_o,
    output logic                illegal_o,

    // writeback straight from the cdb
    output logic                wb_valid_o,
    output ooo_pkg::tag_t       wb_tag_o,
    output ooo_pkg::reg_idx_t   wb_rd_o,
    output ooo_pkg::word_t      wb_data_o,
    output ooo_pkg::word_t      wb_pc_o
);

    rs_if rs_bus [ooo_pkg::NUM_RS] ();
    cdb_if cdb_bus ();

    issue_unit i_issue_unit (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .instr_take_o  (instr_take_o),
        .illegal_o     (illegal_o),
        .rs            (rs_bus),
        .cdb           (cdb_bus)
    );

    // slot g carries tag g+1
    for (genvar g = 0; g < ooo_pkg::NUM_RS; g++) begin : g_rs
        rs_entry #(
            .SLOT_TAG (ooo_pkg::tag_t'(g + 1))
        ) i_rs_entry (
            .clk  (clk),
            .rst  (rst),
            .slot (rs_bus[g]),
            .cdb  (cdb_bus)
        );
    end

    exec_broadcast i_exec_broadcast (
        .clk (clk),
        .rst (rst),
        .rs  (rs_bus),
        .cdb (cdb_bus)
    );

    assign wb_valid_o = cdb_bus.valid;
    assign wb_tag_o = cdb_bus.tag;
    assign wb_rd_o = cdb_bus.rd;
    assign wb_data_o = cdb_bus.data;
    assign wb_pc_o = cdb_bus.pc;

endmodule

//--- hdl/exec_broadcast.sv
`timescale 1ns/1ns

module exec_broadcast (
    input  logic  clk,
    input  logic  rst,
    rs_if.execute rs [ooo_pkg::NUM_RS],
    cdb_if.driver cdb
);

    logic [ooo_pkg::NUM_RS-1:0] ready_vec;
    logic [ooo_pkg::NUM_RS-1:0] grant_vec;
    ooo_pkg::alu_op_e op_a [ooo_pkg::NUM_RS];
    ooo_pkg::word_t vj_a [ooo_pkg::NUM_RS];
    ooo_pkg::word_t vk_a [ooo_pkg::NUM_RS];
    ooo_pkg::reg_idx_t rd_a [ooo_pkg::NUM_RS];
    ooo_pkg::word_t pc_a [ooo_pkg::NUM_RS];

    logic any_ready;
    ooo_pkg::slot_idx_t sel_idx;
    ooo_pkg::word_t a;
    ooo_pkg::word_t b;
    ooo_pkg::word_t result;

    for (genvar g = 0; g < ooo_pkg::NUM_RS; g++) begin : g_slot
        assign ready_vec[g] = rs[g].ready;
        assign op_a[g] = rs[g].op;
        assign vj_a[g] = rs[g].vj;
        assign vk_a[g] = rs[g].vk;
        assign rd_a[g] = rs[g].rd;
        assign pc_a[g] = rs[g].pc;
        assign grant_vec[g] = any_ready && (sel_idx == ooo_pkg::slot_idx_t'(g));
        assign rs[g].grant = grant_vec[g];
    end

    // lowest ready slot wins
    always_comb begin
        any_ready = 1'b0;
        sel_idx = '0;
        for (int i = ooo_pkg::NUM_RS - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                any_ready = 1'b1;
                sel_idx = ooo_pkg::slot_idx_t'(i);
            end
        end
    end

    assign a = vj_a[sel_idx];
    assign b = vk_a[sel_idx];

    always_comb begin
        case (op_a[sel_idx])
            ooo_pkg::ALU_ADD:  result = a + b;
            ooo_pkg::ALU_SUB:  result = a - b;
            ooo_pkg::ALU_SLL:  result = a << b[4:0];
            ooo_pkg::ALU_SLT:  result = {{(ooo_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ooo_pkg::ALU_SLTU: result = {{(ooo_pkg::XLEN-1){1'b0}}, a < b};
            ooo_pkg::ALU_XOR:  result = a ^ b;
            ooo_pkg::ALU_SRL:  result = a >> b[4:0];
            ooo_pkg::ALU_SRA:  result = ooo_pkg::word_t'($signed(a) >>> b[4:0]);
            ooo_pkg::ALU_OR:   result = a | b;
            default:           result = a & b;
        endcase
    end

    // broadcast one cycle after grant, tag stays in 1..NUM_RS
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
            cdb.tag <= ooo_pkg::tag_t'(1);
        end else begin
            cdb.valid <= any_ready;
            cdb.tag <= ooo_pkg::tag_t'(sel_idx) + ooo_pkg::tag_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        cdb.data <= result;
        cdb.rd <= rd_a[sel_idx];
        cdb.pc <= pc_a[sel_idx];
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(grant_vec)
    );

endmodule

//--- hdl/rs_entry.sv
`timescale 1ns/1ns

module rs_entry #(
    parameter ooo_pkg::tag_t SLOT_TAG = ooo_pkg::tag_t'(1)
) (
    input  logic    clk,
    input  logic    rst,
    rs_if.slot      slot,
    cdb_if.listener cdb
);

    logic busy;
    ooo_pkg::tag_t qj;
    ooo_pkg::tag_t qk;
    logic hit_j;
    logic hit_k;

    ooo_pkg::alu_op_e op;
    ooo_pkg::word_t vj;
    ooo_pkg::word_t vk;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::word_t pc;

    // tag match on the bus
    assign hit_j = cdb.valid && (qj != '0) && (qj == cdb.tag);
    assign hit_k = cdb.valid && (qk != '0) && (qk == cdb.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            qj <= '0;
            qk <= '0;
        end else if (slot.disp_we) begin
            busy <= 1'b1;
            qj <= slot.disp_qj;
            qk <= slot.disp_qk;
        end else begin
            if (slot.grant) begin
                busy <= 1'b0;
            end
            if (hit_j) begin
                qj <= '0;
            end
            if (hit_k) begin
                qk <= '0;
            end
        end
    end

    // operation payload
    always_ff @(posedge clk) begin
        if (slot.disp_we) begin
            op <= slot.disp_op;
            vj <= slot.disp_vj;
            vk <= slot.disp_vk;
            rd <= slot.disp_rd;
            pc <= slot.disp_pc;
        end else begin
            if (hit_j) begin
                vj <= cdb.data;
            end
            if (hit_k) begin
                vk <= cdb.data;
            end
        end
    end

    assign slot.busy = busy;
    assign slot.ready = busy && (qj == '0) && (qk == '0);
    assign slot.op = op;
    assign slot.vj = vj;
    assign slot.vk = vk;
    assign slot.rd = rd;
    assign slot.pc = pc;

    a_no_load_busy: assert property (
        @(posedge clk) disable iff (rst) slot.disp_we |-> !busy
    );

    // own result can never be an operand, bypass resolves a freed tag
    a_no_self_wait: assert property (
        @(posedge clk) disable iff (rst) busy |-> (qj != SLOT_TAG) && (qk != SLOT_TAG)
    );

endmodule

//--- hdl/issue_unit.sv
`timescale 1ns/1ns

module issue_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid_i,
    input  ooo_pkg::instr_t     instr_i,
    input  ooo_pkg::word_t      pc_i,
    output logic                instr_take_o,
    output logic                illegal_o,
    rs_if.issue                 rs [ooo_pkg::NUM_RS],
    cdb_if.listener             cdb
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic alt;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::reg_idx_t rs1;
    ooo_pkg::reg_idx_t rs2;
    ooo_pkg::word_t i_imm;
    ooo_pkg::word_t u_imm;

    logic is_lui;
    logic is_auipc;
    logic is_imm;
    logic is_reg;
    logic accepted;
    logic dispatch;

    ooo_pkg::alu_op_e op;
    ooo_pkg::word_t op_vj;
    ooo_pkg::word_t op_vk;
    ooo_pkg::tag_t op_qj;
    ooo_pkg::tag_t op_qk;

    // architectural state and rename table
    ooo_pkg::word_t regs [ooo_pkg::NUM_REGS];
    ooo_pkg::tag_t rtag [ooo_pkg::NUM_REGS];

    ooo_pkg::tag_t src1_raw;
    ooo_pkg::tag_t src2_raw;
    logic src1_hit;
    logic src2_hit;
    ooo_pkg::word_t src1_val;
    ooo_pkg::word_t src2_val;
    ooo_pkg::tag_t src1_tag;
    ooo_pkg::tag_t src2_tag;

    logic [ooo_pkg::NUM_RS-1:0] busy_vec;
    logic any_free;
    ooo_pkg::slot_idx_t free_idx;
    ooo_pkg::tag_t free_tag;

    // field split
    assign opcode = instr_i[ooo_pkg::OPC_LSB +: 7];
    assign rd = instr_i[ooo_pkg::RD_LSB +: $bits(ooo_pkg::reg_idx_t)];
    assign funct3 = instr_i[ooo_pkg::F3_LSB +: 3];
    assign rs1 = instr_i[ooo_pkg::RS1_LSB +: $bits(ooo_pkg::reg_idx_t)];
    assign rs2 = instr_i[ooo_pkg::RS2_LSB +: $bits(ooo_pkg::reg_idx_t)];
    assign alt = instr_i[ooo_pkg::F7_LSB + 5];
    assign i_imm = {{(ooo_pkg::XLEN-12){instr_i[ooo_pkg::XLEN-1]}},
                    instr_i[ooo_pkg::RS2_LSB +: 12]};
    assign u_imm = {instr_i[ooo_pkg::F3_LSB +: 20], 12'h000};

    assign is_lui = (opcode == ooo_pkg::OPC_LUI);
    assign is_auipc = (opcode == ooo_pkg::OPC_AUIPC);
    assign is_imm = (opcode == ooo_pkg::OPC_IMM);
    assign is_reg = (opcode == ooo_pkg::OPC_REG);
    assign accepted = is_lui | is_auipc | is_imm | is_reg;

    // funct3 to alu op, bit 30 picks sub and sra
    always_comb begin
        case (funct3)
            3'd0: op = (is_reg && alt) ? ooo_pkg::ALU_SUB : ooo_pkg::ALU_ADD;
            3'd1: op = ooo_pkg::ALU_SLL;
            3'd2: op = ooo_pkg::ALU_SLT;
            3'd3: op = ooo_pkg::ALU_SLTU;
            3'd4: op = ooo_pkg::ALU_XOR;
            3'd5: op = alt ? ooo_pkg::ALU_SRA : ooo_pkg::ALU_SRL;
            3'd6: op = ooo_pkg::ALU_OR;
            default: op = ooo_pkg::ALU_AND;
        endcase
        if (is_lui || is_auipc) begin
            op = ooo_pkg::ALU_ADD;
        end
    end

    // source read with same-cycle cdb bypass
    assign src1_raw = rtag[rs1];
    assign src2_raw = rtag[rs2];
    assign src1_hit = cdb.valid && (src1_raw != '0) && (src1_raw == cdb.tag);
    assign src2_hit = cdb.valid && (src2_raw != '0) && (src2_raw == cdb.tag);
    assign src1_val = src1_hit ? cdb.data : regs[rs1];
    assign src2_val = src2_hit ? cdb.data : regs[rs2];
    assign src1_tag = src1_hit ? '0 : src1_raw;
    assign src2_tag = src2_hit ? '0 : src2_raw;

    always_comb begin
        op_vj = src1_val;
        op_qj = src1_tag;
        op_vk = src2_val;
        op_qk = src2_tag;
        if (is_lui) begin
            op_vj = '0;
            op_qj = '0;
        end else if (is_auipc) begin
            op_vj = pc_i;
            op_qj = '0;
        end
        if (is_lui || is_auipc) begin
            op_vk = u_imm;
            op_qk = '0;
        end else if (is_imm) begin
            op_vk = i_imm;
            op_qk = '0;
        end
    end

    // lowest free slot
    always_comb begin
        any_free = 1'b0;
        free_idx = '0;
        for (int i = ooo_pkg::NUM_RS - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                any_free = 1'b1;
                free_idx = ooo_pkg::slot_idx_t'(i);
            end
        end
    end

    assign free_tag = ooo_pkg::tag_t'(free_idx) + ooo_pkg::tag_t'(1);

    assign instr_take_o = instr_valid_i && (!accepted || any_free);
    assign illegal_o = instr_valid_i && !accepted;
    // x0 results are dropped here
    assign dispatch = instr_valid_i && accepted && any_free && (rd != '0);

    for (genvar g = 0; g < ooo_pkg::NUM_RS; g++) begin : g_slot
        assign busy_vec[g] = rs[g].busy;
        assign rs[g].disp_we = dispatch && (free_idx == ooo_pkg::slot_idx_t'(g));
        assign rs[g].disp_op = op;
        assign rs[g].disp_vj = op_vj;
        assign rs[g].disp_vk = op_vk;
        assign rs[g].disp_qj = op_qj;
        assign rs[g].disp_qk = op_qk;
        assign rs[g].disp_rd = rd;
        assign rs[g].disp_pc = pc_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
                rtag[i] <= '0;
            end
        end else begin
            // stale producers do not overwrite
            if (cdb.valid && (rtag[cdb.rd] == cdb.tag)) begin
                regs[cdb.rd] <= cdb.data;
                rtag[cdb.rd] <= '0;
            end
            // a new rename wins over the clear
            if (dispatch) begin
                rtag[rd] <= free_tag;
            end
        end
    end

    a_take_needs_valid: assert property (
        @(posedge clk) disable iff (rst) instr_take_o |-> instr_valid_i
    );

endmodule

//--- hdl/cdb_if.sv
`timescale 1ns/1ns

interface cdb_if;

    // one result per cycle at most
    logic valid;
    ooo_pkg::tag_t tag;
    ooo_pkg::word_t data;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::word_t pc;

    modport driver (
        output valid,
        output tag,
        output data,
        output rd,
        output pc
    );

    modport listener (
        input valid,
        input tag,
        input data,
        input rd,
        input pc
    );

endinterface

//--- hdl/rs_if.sv
`timescale 1ns/1ns

interface rs_if;

    // dispatch from issue
    logic disp_we;
    ooo_pkg::alu_op_e disp_op;
    ooo_pkg::word_t disp_vj;
    ooo_pkg::word_t disp_vk;
    ooo_pkg::tag_t disp_qj;
    ooo_pkg::tag_t disp_qk;
    ooo_pkg::reg_idx_t disp_rd;
    ooo_pkg::word_t disp_pc;

    // slot status and held operation
    logic busy;
    logic ready;
    ooo_pkg::alu_op_e op;
    ooo_pkg::word_t vj;
    ooo_pkg::word_t vk;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::word_t pc;

    // execute select
    logic grant;

    modport issue (output disp_we, disp_op, disp_vj, disp_vk, disp_qj, disp_qk,
                   disp_rd, disp_pc, input busy);
    modport slot (input disp_we, disp_op, disp_vj, disp_vk, disp_qj, disp_qk,
                  disp_rd, disp_pc, grant,
                  output busy, ready, op, vj, vk, rd, pc);
    modport execute (input ready, op, vj, vk, rd, pc, output grant);

endinterface

//--- hdl/ooo_pkg.sv
package ooo_pkg;

    // core sizing
    localparam int NUM_RS = 4;
    localparam int TAG_W = 3;
    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;
    localparam int SLOT_W = $clog2(NUM_RS);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [31:0] instr_t;
    typedef logic [SLOT_W-1:0] slot_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // accepted major opcodes
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_REG = 7'b0110011;

    // field positions inside instr_t
    localparam int OPC_LSB = 0;
    localparam int RD_LSB = 7;
    localparam int F3_LSB = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB = 25;

endpackage
